// ==== rtl/axi_mem_pkg.sv ====
/* axi sram slave shared definitions
   bus widths, burst/response codes and array depth */
package axi_mem_pkg;

   // bus widths
   localparam int addr_w = 32;
   localparam int data_w = 32;
   localparam int strb_w = data_w / 8; // one strobe per byte lane
   localparam int len_w  = 8;          // axlen as beats minus one

   // backing array holds 4 KiB of words
   localparam int mem_words = 1024;
   localparam int word_aw   = 10;      // log2(mem_words)

   // only full-width beats are supported
   localparam logic [2:0] size_word = 3'b010; // 4 bytes

   // axburst encoding
   typedef logic [1:0] axi_burst_t;

   localparam axi_burst_t burst_fixed = 2'b00;
   localparam axi_burst_t burst_incr  = 2'b01;
   localparam axi_burst_t burst_wrap  = 2'b10;

   // xresp encoding without exokay or decerr
   typedef logic [1:0] axi_resp_t;

   localparam axi_resp_t resp_okay   = 2'b00;
   localparam axi_resp_t resp_slverr = 2'b10;

endpackage

// ==== rtl/axi_burst_addr.sv ====
/* address channel decoder that latches one AR/AW request, checks legality
   and walks the per-beat word address for fixed, incr and wrap bursts */
module axi_burst_addr
   import axi_mem_pkg::*;
(
   input  logic               clk,
   input  logic               rst,
   input  logic [addr_w-1:0]  addr,
   input  logic [len_w-1:0]   len,
   input  logic [2:0]         size,
   input  axi_burst_t         burst,
   input  logic               valid,
   input  logic               step,      // current beat consumed by channel
   output logic               ready,
   output logic               busy,
   output logic [word_aw-1:0] beat_addr,
   output logic               beat_err,
   output logic               last_beat
);

   logic [word_aw:0]   cur_word;  // extra msb flags incr overrun
   logic [word_aw:0]   next_word;
   logic [word_aw:0]   wrap_mask;
   logic [len_w-1:0]   len_q;
   logic [len_w-1:0]   beat_cnt;
   axi_burst_t         burst_q;
   logic               req_err;   // whole burst illegal
   logic               bad_size;
   logic               bad_wrap;
   logic               bad_addr;

   assign ready = ~busy;

   // legality of the incoming request
   assign bad_size = (size != size_word);
   assign bad_addr = (addr[addr_w-1:word_aw+2] != '0); // past top of array
   always_comb begin
      bad_wrap = 1'b0;
      if (burst == burst_wrap)
         bad_wrap = !(len == 8'd1 || len == 8'd3 || len == 8'd7 || len == 8'd15);
      else if (burst == 2'b11)
         bad_wrap = 1'b1; // reserved burst type
   end

   // beats are one word each, so beat count minus one is the wrap mask
   assign wrap_mask = {{(word_aw-3){1'b0}}, len_q[3:0]};

   always_comb begin
      case (burst_q)
         burst_fixed: next_word = cur_word;
         burst_wrap:  next_word = (cur_word & ~wrap_mask) | ((cur_word + 1'b1) & wrap_mask);
         default:     next_word = cur_word + 1'b1; // incr
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         busy <= 1'b0;
      end else if (valid && ready) begin
         busy <= 1'b1;
      end else if (step && last_beat) begin
         busy <= 1'b0; // burst done
      end
   end

   // request payload and walking address
   always_ff @(posedge clk) begin
      if (valid && ready) begin
         cur_word <= {1'b0, addr[word_aw+1:2]}; // byte to word index
         len_q    <= len;
         burst_q  <= burst;
         req_err  <= bad_size | bad_wrap | bad_addr;
         beat_cnt <= '0;
      end else if (step) begin
         cur_word <= next_word;
         beat_cnt <= beat_cnt + 1'b1;
      end
   end

   assign beat_addr = cur_word[word_aw-1:0];
   assign beat_err  = req_err | cur_word[word_aw]; // illegal burst or incr overrun
   assign last_beat = (beat_cnt == len_q);

   // channel only consumes beats of a captured burst
   a_step_busy: assert property (@(posedge clk) disable iff (rst) step |-> busy);

endmodule

// ==== rtl/sram_array.sv ====
/* single port word sram with byte strobed writes and one cycle registered reads
   where the write side always wins the port and a read is granted only when no write */
module sram_array
   import axi_mem_pkg::*;
(
   input  logic               clk,
   input  logic               wr_req,
   input  logic [word_aw-1:0] wr_addr,
   input  logic [data_w-1:0]  wr_data,
   input  logic [strb_w-1:0]  wr_strb,
   input  logic               rd_req,
   input  logic [word_aw-1:0] rd_addr,
   output logic               rd_gnt,
   output logic [data_w-1:0]  rd_data
);

   logic [data_w-1:0] mem [mem_words];

   // write priority on the shared port
   assign rd_gnt = rd_req & ~wr_req;

   // strobed write that lands at the accepting edge
   always_ff @(posedge clk) begin
      if (wr_req) begin
         for (int i = 0; i < strb_w; i++) begin
            if (wr_strb[i])
               mem[wr_addr][8*i +: 8] <= wr_data[8*i +: 8];
         end
      end
   end

   // read register holds its word until the next granted read
   always_ff @(posedge clk) begin
      if (rd_gnt)
         rd_data <= mem[rd_addr];
   end

   // a write cycle never updates the read register
   a_one_port: assert property (@(posedge clk) wr_req |=> $stable(rd_data));

endmodule

// ==== rtl/axi_read_channel.sv ====
/* read result block that fetches burst beats from the array and returns them
   on R with rlast, one array read outstanding plus one held output beat */
module axi_read_channel
   import axi_mem_pkg::*;
(
   input  logic               clk,
   input  logic               rst,
   input  logic               busy,
   input  logic [word_aw-1:0] beat_addr,
   input  logic               beat_err,
   input  logic               last_beat,
   input  logic               rd_gnt,
   input  logic [data_w-1:0]  rd_data,
   input  logic               rready,
   output logic               step,
   output logic               rd_req,
   output logic [word_aw-1:0] rd_addr,
   output logic [data_w-1:0]  rdata,
   output axi_resp_t          rresp,
   output logic               rlast,
   output logic               rvalid
);

   typedef enum logic [1:0] {
      st_idle      = 2'b00, // waiting for a decoded burst
      st_fetch     = 2'b01, // beats being issued
      st_last_send = 2'b11  // last beat issued and waiting for rlast handshake
   } rd_state_t;

   rd_state_t st;
   logic      pend;       // array read data waiting in rd_data
   logic      pend_last;  // that read is the final beat
   logic      out_free;   // output slot empty or being taken
   logic      can_issue;
   logic      load;       // move array data into output slot
   logic      err_issue;  // error beat straight to output

   assign out_free  = ~rvalid | rready;
   assign can_issue = busy & out_free & (st != st_last_send);
   assign load      = pend & out_free;

   // good beats go to the array and bad ones skip it
   assign rd_req    = can_issue & ~beat_err;
   assign rd_addr   = beat_addr;
   assign err_issue = can_issue & beat_err & ~pend; // keep beat order behind array read
   assign step      = (rd_req & rd_gnt) | err_issue;

   always_ff @(posedge clk) begin
      if (rst) begin
         st <= st_idle;
      end else begin
         case (st)
            st_idle:      if (step) st <= last_beat ? st_last_send : st_fetch;
            st_fetch:     if (step && last_beat) st <= st_last_send;
            st_last_send: if (rvalid && rready && rlast) st <= st_idle;
            default:      st <= st_idle;
         endcase
      end
   end

   // outstanding array read tracking
   always_ff @(posedge clk) begin
      if (rst)
         pend <= 1'b0;
      else if (rd_req && rd_gnt)
         pend <= 1'b1;
      else if (load)
         pend <= 1'b0;
   end

   always_ff @(posedge clk) begin
      if (rd_req && rd_gnt)
         pend_last <= last_beat;
   end

   // output slot control
   always_ff @(posedge clk) begin
      if (rst) begin
         rvalid <= 1'b0;
         rlast  <= 1'b0;
      end else if (load) begin
         rvalid <= 1'b1;
         rlast  <= pend_last;
      end else if (err_issue) begin
         rvalid <= 1'b1;
         rlast  <= last_beat;
      end else if (rvalid && rready) begin
         rvalid <= 1'b0;
         rlast  <= 1'b0;
      end
   end

   // output slot payload
   always_ff @(posedge clk) begin
      if (load) begin
         rdata <= rd_data;
         rresp <= resp_okay;
      end else if (err_issue) begin
         rdata <= '0;          // no data on slverr
         rresp <= resp_slverr;
      end
   end

   // R payload held while master stalls
   a_r_hold: assert property (@(posedge clk) disable iff (rst)
      rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rlast));

endmodule

// ==== rtl/axi_write_channel.sv ====
/* write result block that takes W beats into the array at the handshake edge
   and returns one B response per burst, slverr if any beat was bad */
module axi_write_channel
   import axi_mem_pkg::*;
(
   input  logic               clk,
   input  logic               rst,
   input  logic               busy,
   input  logic [word_aw-1:0] beat_addr,
   input  logic               beat_err,
   input  logic               last_beat,
   input  logic [data_w-1:0]  wdata,
   input  logic [strb_w-1:0]  wstrb,
   input  logic               wlast,
   input  logic               wvalid,
   input  logic               bready,
   output logic               step,
   output logic               wready,
   output logic               wr_req,
   output logic [word_aw-1:0] wr_addr,
   output logic [data_w-1:0]  wr_data,
   output logic [strb_w-1:0]  wr_strb,
   output axi_resp_t          bresp,
   output logic               bvalid
);

   typedef enum logic [1:0] {
      st_idle    = 2'b00, // no beat of the burst taken yet
      st_receive = 2'b01, // collecting W beats
      st_resp    = 2'b11  // B response pending
   } wr_state_t;

   wr_state_t st;
   logic      wfire;
   logic      err_acc; // sticky over the burst

   // W accepted whenever a burst is decoded and B is not outstanding
   assign wready = busy & (st != st_resp);
   assign wfire  = wvalid & wready;
   assign step   = wfire;

   // straight to the array, written at the accepting edge
   assign wr_req  = wfire & ~beat_err;
   assign wr_addr = beat_addr;
   assign wr_data = wdata;
   assign wr_strb = wstrb;

   always_ff @(posedge clk) begin
      if (rst) begin
         st <= st_idle;
      end else begin
         case (st)
            st_idle: begin
               if (wfire)
                  st <= last_beat ? st_resp : st_receive; // single beat goes direct
            end
            st_receive: begin
               if (wfire && last_beat)
                  st <= st_resp;
            end
            st_resp: begin
               if (bready)
                  st <= st_idle; // bvalid high here, so this is the B handshake
            end
            default: st <= st_idle;
         endcase
      end
   end

   // first beat restarts the error flag and later beats or into it
   always_ff @(posedge clk) begin
      if (rst)
         err_acc <= 1'b0;
      else if (wfire)
         err_acc <= (st == st_idle) ? beat_err : (err_acc | beat_err);
   end

   assign bvalid = (st == st_resp);
   assign bresp  = err_acc ? resp_slverr : resp_okay;

   // master's wlast agrees with the decoded burst length
   a_wlast_match: assert property (@(posedge clk) disable iff (rst)
      wfire && wlast |-> last_beat);

endmodule

// ==== rtl/axi_sram_top.sv ====
/* axi4 slave memory top with one decoder per address channel, the shared
   single port array, and the read and write result channels */
module axi_sram_top
   import axi_mem_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   // read address
   input  logic [addr_w-1:0] araddr,
   input  logic [len_w-1:0]  arlen,
   input  logic [2:0]        arsize,
   input  axi_burst_t        arburst,
   input  logic              arvalid,
   output logic              arready,
   // read data
   output logic [data_w-1:0] rdata,
   output axi_resp_t         rresp,
   output logic              rlast,
   output logic              rvalid,
   input  logic              rready,
   // write address
   input  logic [addr_w-1:0] awaddr,
   input  logic [len_w-1:0]  awlen,
   input  logic [2:0]        awsize,
   input  axi_burst_t        awburst,
   input  logic              awvalid,
   output logic              awready,
   // write data
   input  logic [data_w-1:0] wdata,
   input  logic [strb_w-1:0] wstrb,
   input  logic              wlast,
   input  logic              wvalid,
   output logic              wready,
   // write response
   output axi_resp_t         bresp,
   output logic              bvalid,
   input  logic              bready
);

   // read decoder to read channel
   logic               rd_busy;
   logic [word_aw-1:0] rd_beat_addr;
   logic               rd_beat_err;
   logic               rd_last_beat;
   logic               rd_step;

   // write decoder to write channel
   logic               wr_busy;
   logic [word_aw-1:0] wr_beat_addr;
   logic               wr_beat_err;
   logic               wr_last_beat;
   logic               wr_step;

   // channels to array
   logic               mem_rd_req;
   logic [word_aw-1:0] mem_rd_addr;
   logic               mem_rd_gnt;
   logic [data_w-1:0]  mem_rd_data;
   logic               mem_wr_req;
   logic [word_aw-1:0] mem_wr_addr;
   logic [data_w-1:0]  mem_wr_data;
   logic [strb_w-1:0]  mem_wr_strb;

   axi_burst_addr u_rd_dec (
      .clk       (clk),
      .rst       (rst),
      .addr      (araddr),
      .len       (arlen),
      .size      (arsize),
      .burst     (arburst),
      .valid     (arvalid),
      .step      (rd_step),
      .ready     (arready),
      .busy      (rd_busy),
      .beat_addr (rd_beat_addr),
      .beat_err  (rd_beat_err),
      .last_beat (rd_last_beat)
   );

   axi_burst_addr u_wr_dec (
      .clk       (clk),
      .rst       (rst),
      .addr      (awaddr),
      .len       (awlen),
      .size      (awsize),
      .burst     (awburst),
      .valid     (awvalid),
      .step      (wr_step),
      .ready     (awready),
      .busy      (wr_busy),
      .beat_addr (wr_beat_addr),
      .beat_err  (wr_beat_err),
      .last_beat (wr_last_beat)
   );

   sram_array u_mem (
      .clk     (clk),
      .wr_req  (mem_wr_req),
      .wr_addr (mem_wr_addr),
      .wr_data (mem_wr_data),
      .wr_strb (mem_wr_strb),
      .rd_req  (mem_rd_req),
      .rd_addr (mem_rd_addr),
      .rd_gnt  (mem_rd_gnt),
      .rd_data (mem_rd_data)
   );

   axi_read_channel u_rd (
      .clk       (clk),
      .rst       (rst),
      .busy      (rd_busy),
      .beat_addr (rd_beat_addr),
      .beat_err  (rd_beat_err),
      .last_beat (rd_last_beat),
      .rd_gnt    (mem_rd_gnt),
      .rd_data   (mem_rd_data),
      .rready    (rready),
      .step      (rd_step),
      .rd_req    (mem_rd_req),
      .rd_addr   (mem_rd_addr),
      .rdata     (rdata),
      .rresp     (rresp),
      .rlast     (rlast),
      .rvalid    (rvalid)
   );

   axi_write_channel u_wr (
      .clk       (clk),
      .rst       (rst),
      .busy      (wr_busy),
      .beat_addr (wr_beat_addr),
      .beat_err  (wr_beat_err),
      .last_beat (wr_last_beat),
      .wdata     (wdata),
      .wstrb     (wstrb),
      .wlast     (wlast),
      .wvalid    (wvalid),
      .bready    (bready),
      .step      (wr_step),
      .wready    (wready),
      .wr_req    (mem_wr_req),
      .wr_addr   (mem_wr_addr),
      .wr_data   (mem_wr_data),
      .wr_strb   (mem_wr_strb),
      .bresp     (bresp),
      .bvalid    (bvalid)
   );

endmodule

// ==== sim/tb_axi_sram.sv ====
/* testbench for the axi4 sram slave with a table of bursts applied in a loop,
   checked against a reference word array that follows the burst rules */
module tb_axi_sram
   import axi_mem_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int period = 100;   // ns
   localparam int seed   = 2;
   localparam int op_wr    = 0;   // write with bready high
   localparam int op_rd    = 1;   // read with rready high
   localparam int op_rd_bp = 2;   // read with random rready
   localparam int op_wr_bp = 3;   // write with bready held low a while

   logic              clk;
   logic              rst;
   logic [addr_w-1:0] araddr;
   logic [len_w-1:0]  arlen;
   logic [2:0]        arsize;
   logic [1:0]        arburst;
   logic              arvalid;
   logic              arready;
   logic [data_w-1:0] rdata;
   logic [1:0]        rresp;
   logic              rlast;
   logic              rvalid;
   logic              rready;
   logic [addr_w-1:0] awaddr;
   logic [len_w-1:0]  awlen;
   logic [2:0]        awsize;
   logic [1:0]        awburst;
   logic              awvalid;
   logic              awready;
   logic [data_w-1:0] wdata;
   logic [strb_w-1:0] wstrb;
   logic              wlast;
   logic              wvalid;
   logic              wready;
   logic [1:0]        bresp;
   logic              bvalid;
   logic              bready;

   // test table with one entry per row in each queue
   string      t_name[$];
   int         t_op[$];
   int         t_addr[$];         // byte address
   int         t_len[$];          // beats minus one
   int         t_burst[$];
   int         t_size[$];
   logic [3:0] t_strb[$];
   logic [1:0] t_resp[$];         // B response or worst R response

   logic [data_w-1:0] ref_mem [mem_words]; // expected array contents
   int n_rows   = 0;
   int errs     = 0;                       // errors in current test
   int pass_cnt = 0;
   int fail_cnt = 0;

   axi_sram_top DUT (.*);

   initial begin
      clk = 1'b0;
      forever #(period / 2) clk = ~clk;
   end

   task automatic add_row(input string name, input int op, input int addr, input int len,
                          input int burst, input int size, input logic [3:0] strb,
                          input logic [1:0] resp);
      t_name.push_back(name);
      t_op.push_back(op);
      t_addr.push_back(addr);
      t_len.push_back(len);
      t_burst.push_back(burst);
      t_size.push_back(size);
      t_strb.push_back(strb);
      t_resp.push_back(resp);
   endtask

   // whole burst rejected by the slave
   function automatic bit burst_illegal(input int row);
      if (t_size[row] != 2)
         return 1'b1;
      if (t_burst[row] == 3)
         return 1'b1;
      if (t_burst[row] == 2 && !(t_len[row] inside {1, 3, 7, 15}))
         return 1'b1;
      return t_addr[row] >= mem_words * 4; // start past the array
   endfunction

   // word index of one beat that may land past the array for incr
   function automatic int beat_word(input int row, input int beat);
      int start;
      int n;
      int base;
      start = t_addr[row] / 4;
      n     = t_len[row] + 1;
      if (t_burst[row] == 0)
         return start;                      // fixed
      if (t_burst[row] == 2) begin
         base = (start / n) * n;            // block of the whole burst
         return base + (start - base + beat) % n;
      end
      return start + beat;
   endfunction

   function automatic bit beat_bad(input int row, input int beat);
      return burst_illegal(row) || beat_word(row, beat) >= mem_words;
   endfunction

   task automatic to_drive_point();
      @(posedge clk);
      #5;
   endtask

   task automatic run_write(input int row);
      int n;
      int hold;
      int waited;
      int w;
      bit hs;
      bit seen;
      bit done;
      logic [data_w-1:0] d;
      n    = t_len[row] + 1;
      hold = (t_op[row] == op_wr_bp) ? 6 : 0;
      awaddr  = t_addr[row];
      awlen   = len_w'(t_len[row]);
      awsize  = 3'(t_size[row]);
      awburst = 2'(t_burst[row]);
      awvalid = 1'b1;
      hs = 1'b0;
      while (!hs) begin
         @(negedge clk);
         hs = awready;                      // handshake at the coming edge
         to_drive_point();
      end
      awvalid = 1'b0;
      for (int i = 0; i < n; i++) begin
         d      = $urandom;
         w      = beat_word(row, i);
         wdata  = d;
         wstrb  = t_strb[row];
         wlast  = (i == n - 1);
         wvalid = 1'b1;
         hs = 1'b0;
         while (!hs) begin
            @(negedge clk);
            hs = wready;
            to_drive_point();
         end
         if (!beat_bad(row, i)) begin       // bad beats leave the array alone
            for (int b = 0; b < 4; b++)
               if (t_strb[row][b])
                  ref_mem[w][8*b +: 8] = d[8*b +: 8];
         end
      end
      wvalid = 1'b0;
      wlast  = 1'b0;
      bready = (hold == 0);
      waited = 0;
      seen   = 1'b0;
      done   = 1'b0;
      while (!done) begin
         @(negedge clk);
         if (bvalid && bready) begin
            done = 1'b1;
            if (bresp !== t_resp[row]) begin
               $display("Error %s: bresp expected %0d actual %0d", t_name[row],
                        t_resp[row], bresp);
               errs++;
            end
         end else if (bvalid) begin
            seen = 1'b1;
            waited++;
         end else if (seen) begin
            $display("Error %s: bvalid dropped before bready was given", t_name[row]);
            errs++;
            done = 1'b1;
         end
         to_drive_point();
         if (waited >= hold)
            bready = 1'b1;
      end
      bready = 1'b0;
   endtask

   task automatic run_read(input int row);
      int n;
      int beat;
      int lat;
      bit hs;
      bit bp;
      bit first_seen;
      bit stall;
      logic [data_w-1:0] exp_d;
      logic [data_w-1:0] held_d;
      logic [1:0]        exp_r;
      logic [1:0]        worst;
      n  = t_len[row] + 1;
      bp = (t_op[row] == op_rd_bp);
      araddr  = t_addr[row];
      arlen   = len_w'(t_len[row]);
      arsize  = 3'(t_size[row]);
      arburst = 2'(t_burst[row]);
      arvalid = 1'b1;
      hs = 1'b0;
      while (!hs) begin
         @(negedge clk);
         hs = arready;
         to_drive_point();
      end
      arvalid = 1'b0;
      rready  = bp ? (($urandom % 2) == 1) : 1'b1;
      beat       = 0;
      lat        = 0;                       // edges since the AR handshake
      first_seen = 1'b0;
      stall      = 1'b0;
      held_d     = '0;
      worst      = resp_okay;
      while (beat < n) begin
         @(negedge clk);
         if (stall && (!rvalid || rdata !== held_d)) begin
            $display("Error %s: R beat changed while rready was low", t_name[row]);
            errs++;
         end
         stall  = rvalid && !rready;
         held_d = rdata;
         if (rvalid && !first_seen) begin
            first_seen = 1'b1;
            if (!beat_bad(row, 0) && lat != 2) begin // array read path
               $display("Error %s: first beat latency expected 2 actual %0d",
                        t_name[row], lat);
               errs++;
            end
         end
         if (rvalid && rready) begin
            exp_d = beat_bad(row, beat) ? '0 : ref_mem[beat_word(row, beat)];
            exp_r = beat_bad(row, beat) ? resp_slverr : resp_okay;
            if (rdata !== exp_d) begin
               $display("Error %s: beat %0d rdata expected %h actual %h", t_name[row],
                        beat, exp_d, rdata);
               errs++;
            end
            if (rresp !== exp_r) begin
               $display("Error %s: beat %0d rresp expected %0d actual %0d", t_name[row],
                        beat, exp_r, rresp);
               errs++;
            end
            if (rlast !== (beat == n - 1)) begin
               $display("Error %s: beat %0d rlast expected %0d actual %0d", t_name[row],
                        beat, beat == n - 1, rlast);
               errs++;
            end
            if (rresp === resp_slverr)
               worst = resp_slverr;
            beat++;
         end
         to_drive_point();
         lat++;
         rready = bp ? (($urandom % 2) == 1) : 1'b1;
      end
      rready = 1'b0;
      if (worst !== t_resp[row]) begin
         $display("Error %s: burst response expected %0d actual %0d", t_name[row],
                  t_resp[row], worst);
         errs++;
      end
   endtask

   task automatic build_table();
      add_row("incr1_wr",    op_wr,    'h000,  0, 1, 2, 4'hf, resp_okay);
      add_row("incr1_rd",    op_rd,    'h000,  0, 1, 2, 4'hf, resp_okay);
      add_row("incr4_wr",    op_wr,    'h004,  3, 1, 2, 4'hf, resp_okay);
      add_row("incr4_rd",    op_rd,    'h004,  3, 1, 2, 4'hf, resp_okay);
      add_row("incr16_wr",   op_wr,    'h100, 15, 1, 2, 4'hf, resp_okay);
      add_row("incr16_rd",   op_rd,    'h100, 15, 1, 2, 4'hf, resp_okay);
      add_row("wrap4_rd",    op_rd,    'h108,  3, 2, 2, 4'hf, resp_okay);
      add_row("wrap8_rd",    op_rd,    'h114,  7, 2, 2, 4'hf, resp_okay);
      add_row("wrap4_wr",    op_wr,    'h134,  3, 2, 2, 4'hf, resp_okay);
      add_row("wrap4_chk",   op_rd,    'h130,  3, 1, 2, 4'hf, resp_okay);
      add_row("fixed_wr",    op_wr,    'h200,  3, 0, 2, 4'hf, resp_okay);
      add_row("fixed_rd",    op_rd,    'h200,  0, 1, 2, 4'hf, resp_okay);
      add_row("strb_wr_lo",  op_wr,    'h004,  3, 1, 2, 4'h5, resp_okay);
      add_row("strb_wr_hi",  op_wr,    'h000,  0, 1, 2, 4'h8, resp_okay);
      add_row("strb_rd",     op_rd,    'h000,  4, 1, 2, 4'hf, resp_okay);
      add_row("bad_size_wr", op_wr,    'h100,  3, 1, 1, 4'hf, resp_slverr);
      add_row("bad_wrap_wr", op_wr,    'h108,  2, 2, 2, 4'hf, resp_slverr);
      add_row("bad_size_rd", op_rd,    'h100,  3, 1, 1, 4'hf, resp_slverr);
      add_row("bad_wrap_rd", op_rd,    'h108,  2, 2, 2, 4'hf, resp_slverr);
      add_row("top_wr",      op_wr,    'hff0,  3, 1, 2, 4'hf, resp_okay);
      add_row("overrun_wr",  op_wr,    'hff8,  7, 1, 2, 4'hf, resp_slverr);
      add_row("overrun_rd",  op_rd,    'hff0,  7, 1, 2, 4'hf, resp_slverr);
      add_row("low_chk_rd",  op_rd_bp, 'h000,  4, 1, 2, 4'hf, resp_okay); // overrun wrapped?
      add_row("range_rd",    op_rd,    'h1000, 0, 1, 2, 4'hf, resp_slverr);
      add_row("bp_wr",       op_wr_bp, 'h300, 15, 1, 2, 4'hf, resp_okay);
      add_row("bp_rd",       op_rd_bp, 'h300, 15, 1, 2, 4'hf, resp_okay);
      add_row("err_chk_rd",  op_rd_bp, 'h100, 15, 1, 2, 4'hf, resp_okay); // after bad writes
      n_rows = t_name.size();
   endtask

   // ends a stuck run after a budget that scales with the table
   initial begin
      wait (n_rows > 0);
      #(period * (8 + n_rows * (16 + 20)));
      $display("watchdog: the table did not complete in its cycle budget, run stopped");
      $display("Simulation failed");
      $finish;
   end

   initial begin
      void'($urandom(seed));
      rst     = 1'b1;
      araddr  = '0;
      arlen   = '0;
      arsize  = '0;
      arburst = '0;
      arvalid = 1'b0;
      rready  = 1'b0;
      awaddr  = '0;
      awlen   = '0;
      awsize  = '0;
      awburst = '0;
      awvalid = 1'b0;
      wdata   = '0;
      wstrb   = '0;
      wlast   = 1'b0;
      wvalid  = 1'b0;
      bready  = 1'b0;
      build_table();
      repeat (8) @(posedge clk);
      #5;
      rst = 1'b0;
      @(negedge clk);                        // idle outputs after reset
      if ({arready, awready, rvalid, bvalid, wready} !== 5'b11000) begin
         $display("Error reset_state: ready/valid levels expected %b actual %b", 5'b11000,
                  {arready, awready, rvalid, bvalid, wready});
         fail_cnt++;
      end else begin
         $display("test reset_state: ok");
         pass_cnt++;
      end
      to_drive_point();
      for (int row = 0; row < n_rows; row++) begin
         errs = 0;
         if (t_op[row] == op_wr || t_op[row] == op_wr_bp)
            run_write(row);
         else
            run_read(row);
         if (errs == 0) begin
            $display("test %s: ok", t_name[row]);
            pass_cnt++;
         end else begin
            $display("test %s: %0d errors", t_name[row], errs);
            fail_cnt++;
         end
      end
      $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// ==== flist.f ====
rtl/axi_mem_pkg.sv
rtl/axi_burst_addr.sv
rtl/sram_array.sv
rtl/axi_read_channel.sv
rtl/axi_write_channel.sv
rtl/axi_sram_top.sv
sim/tb_axi_sram.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the axi sram testbench with verilator, run it, and decide pass/fail
# from the simulation output

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --timescale 1ns/1ps \
   --top-module tb_axi_sram -Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/Vtb_axi_sram)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation passed"; then
   exit 0
fi

echo "pass message not found in simulation output"
exit 1
